/* zet_deco_pkg.sv */
package zet_deco_pkg;

        localparam int REG_W   = 4;
        localparam int SEG_W   = 2;
        localparam int MICRO_W = 6;

        typedef logic [REG_W-1:0]   reg_code_t;
        typedef logic [SEG_W-1:0]   seg_code_t;
        typedef logic [MICRO_W-1:0] micro_code_t;

        localparam reg_code_t REG_BX   = 4'b0011;
        localparam reg_code_t REG_BP   = 4'b0101;
        localparam reg_code_t REG_SI   = 4'b0110;
        localparam reg_code_t REG_DI   = 4'b0111;
        localparam reg_code_t REG_NONE = 4'b1100; // no base or index

        localparam seg_code_t SEG_SS = 2'd2;
        localparam seg_code_t SEG_DS = 2'd3;

        typedef enum logic [3:0] {
                CL_INV, CL_ALU_RM, CL_ALU_MR, CL_ALU_IA,
                CL_INC, CL_DEC, CL_PUSH, CL_POP,
                CL_JCC, CL_MOV_RM, CL_MOV_IR, CL_GRP3,
                CL_MOVS, CL_STOS
        } op_class_t;

        // modrm_reg side follows the d bit, modrm_rm is the rm field as is
        typedef enum logic [1:0] {
                SEL_ZERO, SEL_MODRM_REG, SEL_MODRM_RM, SEL_OP_REG
        } reg_sel_t;

        localparam micro_code_t INVOP  = 6'd0;
        localparam micro_code_t LOGRRB = 6'd1;
        localparam micro_code_t LOGRRW = 6'd2;
        localparam micro_code_t LOGRMB = 6'd3;
        localparam micro_code_t LOGRMW = 6'd4;
        localparam micro_code_t LOGMRB = 6'd5;
        localparam micro_code_t LOGMRW = 6'd6;
        localparam micro_code_t LOGIRB = 6'd7;
        localparam micro_code_t LOGIRW = 6'd8;
        localparam micro_code_t INCRW  = 6'd9;
        localparam micro_code_t DECRW  = 6'd10;
        localparam micro_code_t PUSHR  = 6'd11;
        localparam micro_code_t POPR   = 6'd12;
        localparam micro_code_t JCC    = 6'd13;
        localparam micro_code_t MOVRRB = 6'd14;
        localparam micro_code_t MOVRRW = 6'd15;
        localparam micro_code_t MOVRMB = 6'd16;
        localparam micro_code_t MOVRMW = 6'd17;
        localparam micro_code_t MOVMRB = 6'd18;
        localparam micro_code_t MOVMRW = 6'd19;
        localparam micro_code_t MOVIRB = 6'd20;
        localparam micro_code_t MOVIRW = 6'd21;
        localparam micro_code_t TSTIRB = 6'd22;
        localparam micro_code_t TSTIRW = 6'd23;
        localparam micro_code_t TSTIMB = 6'd24;
        localparam micro_code_t TSTIMW = 6'd25;
        localparam micro_code_t NOTRB  = 6'd26;
        localparam micro_code_t NOTRW  = 6'd27;
        localparam micro_code_t NOTMB  = 6'd28;
        localparam micro_code_t NOTMW  = 6'd29;
        localparam micro_code_t NEGRB  = 6'd30;
        localparam micro_code_t NEGRW  = 6'd31;
        localparam micro_code_t NEGMB  = 6'd32;
        localparam micro_code_t NEGMW  = 6'd33;
        localparam micro_code_t MOVSB  = 6'd34;
        localparam micro_code_t MOVSW  = 6'd35;
        localparam micro_code_t MOVSBR = 6'd36;
        localparam micro_code_t MOVSWR = 6'd37;
        localparam micro_code_t STOSB  = 6'd38;
        localparam micro_code_t STOSW  = 6'd39;
        localparam micro_code_t STOSBR = 6'd40;
        localparam micro_code_t STOSWR = 6'd41;

endpackage

/* zet_opcode_class.sv */
module zet_opcode_class
        import zet_deco_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      op_valid,
        input  logic [7:0] op,
        input  logic [2:0] modrm_reg,
        input  logic      reg_mode,
        input  logic      need_off_mod,
        input  logic      off_size_mod,
        output op_class_t op_class,
        output logic      byte_op,
        output reg_sel_t  src_sel,
        output reg_sel_t  dst_sel,
        output logic      load,
        output logic      deco_valid,
        output logic      need_modrm,
        output logic      need_off,
        output logic      need_imm,
        output logic      imm_size,
        output logic      off_size
);

        logic need_modrm_d;
        logic need_off_d;
        logic need_imm_d;
        logic imm_size_d;

        always_comb
        begin
                casez (op)
                8'b00??_?00?: op_class = CL_ALU_RM;
                8'b00??_?01?: op_class = CL_ALU_MR;
                8'b00??_?10?: op_class = CL_ALU_IA; // imm to al/ax
                8'b0100_0???: op_class = CL_INC;
                8'b0100_1???: op_class = CL_DEC;
                8'b0101_0???: op_class = CL_PUSH;
                8'b0101_1???: op_class = CL_POP;
                8'b0111_????: op_class = CL_JCC;
                8'b1000_10??: op_class = CL_MOV_RM;
                8'b1011_????: op_class = CL_MOV_IR;
                8'b1111_011?: op_class = CL_GRP3;
                8'b1010_010?: op_class = CL_MOVS;
                8'b1010_101?: op_class = CL_STOS;
                default:      op_class = CL_INV;
                endcase
        end

        always_comb
        begin
                src_sel      = SEL_ZERO;
                dst_sel      = SEL_ZERO;
                need_modrm_d = 1'b0;
                need_off_d   = 1'b0;
                need_imm_d   = 1'b0;
                imm_size_d   = 1'b0;
                case (op_class)
                CL_ALU_RM, CL_ALU_MR:
                begin
                        src_sel      = SEL_MODRM_REG;
                        dst_sel      = SEL_MODRM_REG;
                        need_modrm_d = 1'b1;
                        need_off_d   = need_off_mod;
                end
                CL_ALU_IA:
                begin
                        need_imm_d = 1'b1;
                        imm_size_d = op[0];
                end
                CL_INC, CL_DEC, CL_PUSH: src_sel = SEL_OP_REG;
                CL_POP:                  dst_sel = SEL_OP_REG;
                CL_JCC:
                begin
                        src_sel    = SEL_OP_REG; // condition code
                        need_imm_d = 1'b1;
                end
                CL_MOV_RM:
                begin
                        need_modrm_d = 1'b1;
                        need_off_d   = need_off_mod & ~reg_mode;
                        if (reg_mode || !op[1])
                                src_sel = SEL_MODRM_REG;
                        if (reg_mode || op[1])
                                dst_sel = SEL_MODRM_REG; // memory side stays zero
                end
                CL_MOV_IR:
                begin
                        dst_sel    = SEL_OP_REG;
                        need_imm_d = 1'b1;
                        imm_size_d = op[3];
                end
                CL_GRP3:
                begin
                        src_sel      = SEL_MODRM_RM;
                        dst_sel      = SEL_MODRM_RM;
                        need_modrm_d = 1'b1;
                        need_off_d   = need_off_mod;
                        need_imm_d   = (modrm_reg == 3'b000); // test only
                        imm_size_d   = need_imm_d & op[0];
                end
                default: ;
                endcase
        end

        assign byte_op = (op_class == CL_MOV_IR) ? ~op[3] : ~op[0];
        assign load    = op_valid;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        deco_valid <= 1'b0;
                        need_modrm <= 1'b0;
                        need_off   <= 1'b0;
                        need_imm   <= 1'b0;
                        imm_size   <= 1'b0;
                        off_size   <= 1'b0;
                end
                else
                begin
                        deco_valid <= op_valid;
                        if (op_valid)
                        begin
                                need_modrm <= need_modrm_d;
                                need_off   <= need_off_d;
                                need_imm   <= need_imm_d;
                                imm_size   <= imm_size_d;
                                off_size   <= need_off_d & off_size_mod;
                        end
                end
        end

endmodule

/* zet_modrm_fields.sv */
module zet_modrm_fields
        import zet_deco_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       load,
        input  logic [7:0] modrm,
        input  logic [2:0] op_low,
        input  logic       d_bit,
        input  reg_sel_t   src_sel,
        input  reg_sel_t   dst_sel,
        output logic [2:0] modrm_reg,
        output logic [2:0] rm,
        output logic [1:0] mod,
        output logic       reg_mode,
        output reg_code_t  src,
        output reg_code_t  dst
);

        logic [2:0] src_m;
        logic [2:0] dst_m;

        function automatic reg_code_t pick(input reg_sel_t sel, input logic [2:0] side,
                                           input logic [2:0] rm_f, input logic [2:0] op_f);
                case (sel)
                SEL_MODRM_REG: return {1'b0, side};
                SEL_MODRM_RM:  return {1'b0, rm_f};
                SEL_OP_REG:    return {1'b0, op_f};
                default:       return 4'b0000;
                endcase
        endfunction

        assign mod       = modrm[7:6];
        assign modrm_reg = modrm[5:3];
        assign rm        = modrm[2:0];
        assign reg_mode  = (mod == 2'b11);

        assign src_m = d_bit ? rm : modrm_reg; // d set, reg is the destination
        assign dst_m = d_bit ? modrm_reg : rm;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        src <= 4'b0000;
                        dst <= 4'b0000;
                end
                else if (load)
                begin
                        src <= pick(src_sel, src_m, rm, op_low);
                        dst <= pick(dst_sel, dst_m, rm, op_low);
                end
        end

endmodule

/* zet_memory_regs.sv */
module zet_memory_regs
        import zet_deco_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       load,
        input  logic [2:0] rm,
        input  logic [1:0] mod,
        input  logic [2:0] sovr_pr,
        output reg_code_t  base,
        output reg_code_t  index,
        output seg_code_t  seg,
        output logic       need_off_mod,
        output logic       off_size_mod
);

        logic      direct;
        reg_code_t base_d;
        reg_code_t index_d;
        seg_code_t seg_d;

        assign direct = (rm == 3'd6) && (mod == 2'b00); // 16-bit direct address

        always_comb
        begin
                case (rm)
                3'd2, 3'd3: base_d = REG_BP;
                3'd4:       base_d = REG_SI;
                3'd5:       base_d = REG_DI;
                3'd6:       base_d = direct ? REG_NONE : REG_BP;
                default:    base_d = REG_BX;
                endcase

                case (rm)
                3'd0, 3'd2: index_d = REG_SI;
                3'd1, 3'd3: index_d = REG_DI;
                default:    index_d = REG_NONE;
                endcase
        end

        assign seg_d = (base_d == REG_BP) ? SEG_SS : SEG_DS; // bp based defaults to ss

        assign need_off_mod = direct | ^mod;
        assign off_size_mod = direct | mod[1];

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        base  <= REG_NONE;
                        index <= REG_NONE;
                        seg   <= SEG_DS;
                end
                else if (load)
                begin
                        base  <= base_d;
                        index <= index_d;
                        seg   <= sovr_pr[2] ? sovr_pr[1:0] : seg_d; // override wins
                end
        end

endmodule

/* zet_seq_addr_sel.sv */
module zet_seq_addr_sel
        import zet_deco_pkg::*;
#(
        parameter int micro_addr_width = 8
)
(
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        load,
        input  op_class_t                   op_class,
        input  logic                        byte_op,
        input  logic                        reg_mode,
        input  logic                        rep,
        input  logic [2:0]                  modrm_reg,
        input  logic                        d_bit,
        output logic [micro_addr_width-1:0] seq_addr
);

        micro_code_t addr_d;

        // register or memory form, then byte or word
        function automatic micro_code_t form(input logic reg_f, input logic byte_f,
                                             input micro_code_t rb, input micro_code_t rw,
                                             input micro_code_t mb, input micro_code_t mw);
                if (reg_f)
                        return byte_f ? rb : rw;
                return byte_f ? mb : mw;
        endfunction

        always_comb
        begin
                case (op_class)
                CL_ALU_RM: addr_d = form(reg_mode, byte_op, LOGRRB, LOGRRW, LOGRMB, LOGRMW);
                CL_ALU_MR: addr_d = form(reg_mode, byte_op, LOGRRB, LOGRRW, LOGMRB, LOGMRW);
                CL_ALU_IA: addr_d = byte_op ? LOGIRB : LOGIRW;
                CL_INC:    addr_d = INCRW;
                CL_DEC:    addr_d = DECRW;
                CL_PUSH:   addr_d = PUSHR;
                CL_POP:    addr_d = POPR;
                CL_JCC:    addr_d = JCC;
                CL_MOV_RM: addr_d = form(reg_mode, byte_op, MOVRRB, MOVRRW,
                                         d_bit ? MOVMRB : MOVRMB,
                                         d_bit ? MOVMRW : MOVRMW);
                CL_MOV_IR: addr_d = byte_op ? MOVIRB : MOVIRW;
                CL_GRP3:
                begin
                        case (modrm_reg)
                        3'b000:  addr_d = form(reg_mode, byte_op, TSTIRB, TSTIRW,
                                               TSTIMB, TSTIMW);
                        3'b010:  addr_d = form(reg_mode, byte_op, NOTRB, NOTRW,
                                               NOTMB, NOTMW);
                        3'b011:  addr_d = form(reg_mode, byte_op, NEGRB, NEGRW,
                                               NEGMB, NEGMW);
                        default: addr_d = INVOP; // mul, imul, div, idiv
                        endcase
                end
                CL_MOVS:   addr_d = rep ? (byte_op ? MOVSBR : MOVSWR)
                                        : (byte_op ? MOVSB : MOVSW);
                CL_STOS:   addr_d = rep ? (byte_op ? STOSBR : STOSWR)
                                        : (byte_op ? STOSB : STOSW);
                default:   addr_d = INVOP;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        seq_addr <= micro_addr_width'(INVOP);
                else if (load)
                        seq_addr <= micro_addr_width'(addr_d); // zero extended
        end

endmodule

/* zet_opcode_deco.sv */
module zet_opcode_deco
        import zet_deco_pkg::*;
#(
        parameter int micro_addr_width = 8
)
(
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        op_valid,
        input  logic [7:0]                  op,
        input  logic [7:0]                  modrm,
        input  logic                        rep,
        input  logic [2:0]                  sovr_pr,
        output logic                        deco_valid,
        output logic [micro_addr_width-1:0] seq_addr,
        output logic                        need_modrm,
        output logic                        need_off,
        output logic                        need_imm,
        output logic                        off_size,
        output logic                        imm_size,
        output reg_code_t                   src,
        output reg_code_t                   dst,
        output reg_code_t                   base,
        output reg_code_t                   index,
        output seg_code_t                   seg
);

        op_class_t  op_class;
        reg_sel_t   src_sel;
        reg_sel_t   dst_sel;
        logic       byte_op;
        logic       load;
        logic       reg_mode;
        logic       need_off_mod;
        logic       off_size_mod;
        logic [2:0] modrm_reg;
        logic [2:0] rm;
        logic [1:0] mod;

        zet_opcode_class opcode_class_i (
                .clk          (clk),
                .rst_n        (rst_n),
                .op_valid     (op_valid),
                .op           (op),
                .modrm_reg    (modrm_reg),
                .reg_mode     (reg_mode),
                .need_off_mod (need_off_mod),
                .off_size_mod (off_size_mod),
                .op_class     (op_class),
                .byte_op      (byte_op),
                .src_sel      (src_sel),
                .dst_sel      (dst_sel),
                .load         (load),
                .deco_valid   (deco_valid),
                .need_modrm   (need_modrm),
                .need_off     (need_off),
                .need_imm     (need_imm),
                .imm_size     (imm_size),
                .off_size     (off_size)
        );

        zet_modrm_fields modrm_fields_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .load      (load),
                .modrm     (modrm),
                .op_low    (op[2:0]),
                .d_bit     (op[1]),
                .src_sel   (src_sel),
                .dst_sel   (dst_sel),
                .modrm_reg (modrm_reg),
                .rm        (rm),
                .mod       (mod),
                .reg_mode  (reg_mode),
                .src       (src),
                .dst       (dst)
        );

        zet_memory_regs memory_regs_i (
                .clk          (clk),
                .rst_n        (rst_n),
                .load         (load),
                .rm           (rm),
                .mod          (mod),
                .sovr_pr      (sovr_pr),
                .base         (base),
                .index        (index),
                .seg          (seg),
                .need_off_mod (need_off_mod),
                .off_size_mod (off_size_mod)
        );

        zet_seq_addr_sel #(
                .micro_addr_width (micro_addr_width)
        ) seq_addr_sel_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .load      (load),
                .op_class  (op_class),
                .byte_op   (byte_op),
                .reg_mode  (reg_mode),
                .rep       (rep),
                .modrm_reg (modrm_reg),
                .d_bit     (op[1]),
                .seq_addr  (seq_addr)
        );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen
#(
        parameter int period       = 4,
        parameter int reset_cycles = 4
)
(
        output logic clk,
        output logic rst_n
);

        initial
        begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        initial
        begin
                rst_n = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1; // released on a falling edge
        end

endmodule

/* tb_deco_checker.sv */
module tb_deco_checker
#(
        parameter int micro_addr_width = 8
)
(
        input logic                        clk,
        input logic                        rst_n,
        input logic                        deco_valid,
        input logic [micro_addr_width-1:0] seq_addr,
        input logic                        need_modrm,
        input logic                        need_off,
        input logic                        need_imm,
        input logic                        off_size,
        input logic                        imm_size,
        input logic [3:0]                  src,
        input logic [3:0]                  dst,
        input logic [3:0]                  base,
        input logic [3:0]                  index,
        input logic [1:0]                  seg
);

        localparam int exp_w = micro_addr_width + 23;

        logic [exp_w-1:0] exp_q[$]; // holds at most one result
        string            name_q[$];
        logic [exp_w-1:0] cur;
        string            cur_name;
        int               value_errs = 0;
        int               protocol_errs = 0;

        task automatic compare_field(input string test, input string field,
                                     input logic [31:0] expected, input logic [31:0] actual);
                if (expected !== actual)
                begin
                        $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                                 test, field, expected, actual);
                        value_errs++;
                end
        endtask

        task automatic check_outputs(input string test, input logic [exp_w-1:0] e);
                compare_field(test, "seq_addr", e[exp_w-1 -: micro_addr_width], seq_addr);
                compare_field(test, "need_modrm", e[22], need_modrm);
                compare_field(test, "need_off", e[21], need_off);
                compare_field(test, "need_imm", e[20], need_imm);
                compare_field(test, "off_size", e[19], off_size);
                compare_field(test, "imm_size", e[18], imm_size);
                compare_field(test, "src", e[17:14], src);
                compare_field(test, "dst", e[13:10], dst);
                compare_field(test, "base", e[9:6], base);
                compare_field(test, "index", e[5:2], index);
                compare_field(test, "seg", e[1:0], seg);
        endtask

        task automatic check_reset_state();
                compare_field("reset", "deco_valid", 0, deco_valid);
                compare_field("reset", "need_modrm", 0, need_modrm);
                compare_field("reset", "need_off", 0, need_off);
                compare_field("reset", "need_imm", 0, need_imm);
                compare_field("reset", "seq_addr", 0, seq_addr); // INVOP
        endtask

        task automatic drop_unanswered();
                while (name_q.size() != 0)
                begin
                        $display("no deco_valid pulse answered %s", name_q.pop_front());
                        exp_q.delete(0);
                        protocol_errs++;
                end
        endtask

        task automatic expect_result(input string name, input logic [exp_w-1:0] e);
                drop_unanswered(); // previous one should be gone by now
                exp_q.push_back(e);
                name_q.push_back(name);
        endtask

        // outputs are settled half a cycle after the capturing edge
        always @(negedge clk)
        begin
                if (rst_n && deco_valid)
                begin
                        if (exp_q.size() == 0)
                        begin
                                $display("deco_valid pulsed with no opcode waiting for a result");
                                protocol_errs++;
                        end
                        else
                        begin
                                cur      = exp_q.pop_front();
                                cur_name = name_q.pop_front();
                                check_outputs(cur_name, cur);
                        end
                end
        end

endmodule

/* zet_deco_assertions.sv */
module zet_deco_assertions
        import zet_deco_pkg::*;
(
        input logic      clk,
        input logic      rst_n,
        input logic      op_valid,
        input logic      deco_valid,
        input logic      need_modrm,
        input logic      need_off,
        input reg_code_t src,
        input reg_code_t dst
);

        int valid_fails = 0;
        int off_fails = 0;
        int code_fails = 0;
        int fail_count;

        assign fail_count = valid_fails + off_fails + code_fails;

        valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
                        deco_valid == $past(op_valid))
                else
                begin
                        $error("deco_valid does not follow op_valid by one cycle");
                        valid_fails++;
                end

        off_needs_modrm: assert property (@(posedge clk) disable iff (!rst_n)
                        need_off |-> need_modrm)
                else
                begin
                        $error("need_off is set without need_modrm");
                        off_fails++;
                end

        // only general registers, never the 1xxx codes
        gp_regs_only: assert property (@(posedge clk) disable iff (!rst_n)
                        !src[3] && !dst[3])
                else
                begin
                        $error("src or dst carries a non general register code");
                        code_fails++;
                end

endmodule

bind zet_opcode_deco zet_deco_assertions assertions_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .deco_valid (deco_valid),
        .need_modrm (need_modrm),
        .need_off   (need_off),
        .src        (src),
        .dst        (dst)
);

/* tb_zet_opcode_deco.sv */
module tb_zet_opcode_deco;

        localparam int addr_w       = 8;
        localparam int period       = 4;
        localparam int reset_cycles = 4;

        logic              clk;
        logic              rst_n;
        logic              op_valid;
        logic [7:0]        op;
        logic [7:0]        modrm;
        logic              rep;
        logic [2:0]        sovr_pr;
        logic              deco_valid;
        logic [addr_w-1:0] seq_addr;
        logic              need_modrm;
        logic              need_off;
        logic              need_imm;
        logic              off_size;
        logic              imm_size;
        logic [3:0]        src;
        logic [3:0]        dst;
        logic [3:0]        base;
        logic [3:0]        index;
        logic [1:0]        seg;

        logic [19:0]        stim_in[$];
        logic [addr_w+22:0] stim_exp[$];
        int                 vec_count = 0;
        int                 seed = 79;

        tb_clk_gen #(.period(period), .reset_cycles(reset_cycles)) clk_gen_i (
                .clk   (clk),
                .rst_n (rst_n)
        );

        zet_opcode_deco #(.micro_addr_width(addr_w)) dut_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .op_valid   (op_valid),
                .op         (op),
                .modrm      (modrm),
                .rep        (rep),
                .sovr_pr    (sovr_pr),
                .deco_valid (deco_valid),
                .seq_addr   (seq_addr),
                .need_modrm (need_modrm),
                .need_off   (need_off),
                .need_imm   (need_imm),
                .off_size   (off_size),
                .imm_size   (imm_size),
                .src        (src),
                .dst        (dst),
                .base       (base),
                .index      (index),
                .seg        (seg)
        );

        tb_deco_checker #(.micro_addr_width(addr_w)) checker_i (.*);

        task automatic load_vectors();
                int    fd;
                int    n;
                string line;
                int    f[15];
                fd = $fopen("deco_stimulus.txt", "r");
                if (fd == 0)
                        return;
                while (!$feof(fd))
                begin
                        line = "";
                        void'($fgets(line, fd));
                        if (line.len() == 0 || line[0] == "#")
                                continue;
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                        if (n == 15)
                        begin
                                stim_in.push_back({f[0][7:0], f[1][7:0], f[2][0], f[3][2:0]});
                                stim_exp.push_back({f[4][addr_w-1:0], f[5][0], f[6][0],
                                                    f[7][0], f[8][0], f[9][0],
                                                    f[10][3:0], f[11][3:0], f[12][3:0],
                                                    f[13][3:0], f[14][1:0]});
                        end
                end
                $fclose(fd);
        endtask

        initial
        begin : stimulus
                int          idle;
                int          total;
                logic [19:0] vin;
                op_valid = 1'b0;
                op       = 8'h00;
                modrm    = 8'h00;
                rep      = 1'b0;
                sovr_pr  = 3'b000;
                load_vectors();
                vec_count = stim_in.size();
                if (vec_count == 0)
                begin
                        $display("no vectors could be read from deco_stimulus.txt");
                        $display("TEST RESULT: FAIL");
                        $finish;
                end
                else
                begin
                        wait (rst_n === 1'b1);
                        @(negedge clk);
                        checker_i.check_reset_state();
                        for (int i = 0; i < vec_count; i++)
                        begin
                                vin = stim_in[i];
                                @(negedge clk);
                                {op, modrm, rep, sovr_pr} = vin;
                                op_valid = 1'b1;
                                @(posedge clk); // captured here
                                checker_i.expect_result($sformatf("vector %0d op %h", i, op),
                                                        stim_exp[i]);
                                idle = $random(seed) & 3; // zero keeps vectors back to back
                                if (idle != 0)
                                begin
                                        @(negedge clk);
                                        op_valid = 1'b0;
                                        repeat (idle - 1) @(negedge clk);
                                end
                        end
                        @(negedge clk);
                        op_valid = 1'b0;
                        repeat (2) @(posedge clk); // result latency is one cycle
                        checker_i.drop_unanswered();
                        total = checker_i.value_errs + checker_i.protocol_errs
                                + dut_i.assertions_i.fail_count;
                        $display("errors: %0d value, %0d protocol, %0d assertion",
                                 checker_i.value_errs, checker_i.protocol_errs,
                                 dut_i.assertions_i.fail_count);
                        if (total == 0)
                                $display("TEST RESULT: PASS");
                        else
                                $display("TEST RESULT: FAIL");
                        $finish;
                end
        end

        initial
        begin : watchdog
                wait (vec_count != 0);
                #((vec_count * 20 + reset_cycles) * period);
                $display("timeout: the run did not finish in %0d cycles",
                         vec_count * 20 + reset_cycles);
                $display("TEST RESULT: FAIL");
                $finish;
        end

endmodule

/* deco_stimulus.txt */
# op modrm rep sovr_pr | seq_addr need_modrm need_off need_imm off_size imm_size
# src dst base index seg, all hex, one vector per line
00 c8 0 0  01 1 0 0 0 0  1 0 3 6 3
01 5a 0 0  04 1 1 0 0 0  3 2 5 6 2
0a af 0 0  05 1 1 0 1 0  7 5 3 c 3
2b f4 0 0  02 1 0 0 0 0  4 6 6 c 3
31 06 0 0  04 1 1 0 1 0  0 6 c c 3
38 13 0 4  03 1 0 0 0 0  2 3 5 7 0
24 00 0 0  07 0 0 1 0 0  0 0 3 6 3
15 00 0 0  08 0 0 1 0 1  0 0 3 6 3
8b 40 0 0  13 1 1 0 0 0  0 0 3 6 3
8b 89 0 5  13 1 1 0 1 0  0 1 3 7 1
89 54 0 0  11 1 1 0 0 0  2 0 6 c 3
88 1d 0 6  10 1 0 0 0 0  3 0 7 c 2
8a a6 0 0  12 1 1 0 1 0  0 4 5 c 2
8b 2e 0 4  13 1 1 0 1 0  0 5 c c 0
89 77 0 7  11 1 1 0 0 0  6 0 3 c 3
8b 7e 0 0  13 1 1 0 0 0  0 7 5 c 2
88 ca 0 0  0e 1 0 0 0 0  1 2 5 6 2
8b c3 0 0  0f 1 0 0 0 0  3 0 5 7 2
41 00 0 0  09 0 0 0 0 0  1 0 3 6 3
4f 00 0 0  0a 0 0 0 0 0  7 0 3 6 3
55 00 0 0  0b 0 0 0 0 0  5 0 3 6 3
5a 00 0 0  0c 0 0 0 0 0  0 2 3 6 3
7c 00 0 0  0d 0 0 1 0 0  4 0 3 6 3
b3 00 0 0  14 0 0 1 0 0  0 3 3 6 3
be 00 0 0  15 0 0 1 0 1  0 6 3 6 3
f6 c1 0 0  16 1 0 1 0 0  1 1 3 7 3
f7 82 0 0  19 1 1 1 1 1  2 2 5 6 2
f7 d5 0 0  1b 1 0 0 0 0  5 5 7 c 3
f6 58 0 0  20 1 1 0 0 0  0 0 3 6 3
f7 e3 0 0  00 1 0 0 0 0  3 3 5 7 2
f6 3e 0 0  00 1 1 0 1 0  6 6 c c 3
a4 00 0 0  22 0 0 0 0 0  0 0 3 6 3
a5 00 1 0  25 0 0 0 0 0  0 0 3 6 3
aa 00 1 0  28 0 0 0 0 0  0 0 3 6 3
ab 00 0 0  27 0 0 0 0 0  0 0 3 6 3
06 00 0 0  00 0 0 0 0 0  0 0 3 6 3
80 c0 0 0  00 0 0 0 0 0  0 0 3 6 3
ff 00 0 0  00 0 0 0 0 0  0 0 3 6 3
8d 00 0 0  00 0 0 0 0 0  0 0 3 6 3

/* files.f */
zet_deco_pkg.sv
zet_opcode_class.sv
zet_modrm_fields.sv
zet_memory_regs.sv
zet_seq_addr_sel.sv
zet_opcode_deco.sv
tb_clk_gen.sv
tb_deco_checker.sv
zet_deco_assertions.sv
tb_zet_opcode_deco.sv

/* Bender.yml */
package:
  name: zet_opcode_deco

sources:
  - zet_deco_pkg.sv
  - zet_opcode_class.sv
  - zet_modrm_fields.sv
  - zet_memory_regs.sv
  - zet_seq_addr_sel.sv
  - zet_opcode_deco.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_deco_checker.sv
      - zet_deco_assertions.sv
      - tb_zet_opcode_deco.sv
